//--- blocking_cache.f
design/cache_pkg.sv
design/cache_ctrl_if.sv
design/cache_way.sv
design/cache_dpath.sv
design/cache_ctrl.sv
design/blocking_cache.sv
verif/tb_mem.sv
verif/cache_tb.sv

//--- verif/cache_tb.sv
/*
 * Testbench for the blocking cache. Applies a table of processor requests and checks
 * each response against a shadow word memory and the memory traffic it caused.
 */
`timescale 1ns/1ps

module cache_tb;

  localparam int         timeout_cycles = 200;
  localparam logic [1:0] chk_hit   = 2'd0;     // No memory traffic
  localparam logic [1:0] chk_clean = 2'd1;     // Refill only
  localparam logic [1:0] chk_wb    = 2'd2;     // Write-back, then refill

  typedef struct packed {
    logic [2:0]  typ;
    logic [31:0] addr;
    logic [31:0] data;
    logic [7:0]  opq;
    logic [1:0]  mem_chk;
    logic [31:0] wb_addr;
  } row_t;

  logic clk, rst_n, cachereq_val, busy, cacheresp_val, memreq_val, memresp_val;
  logic [2:0]   cachereq_type, cacheresp_type, memreq_type;
  logic [7:0]   cachereq_opaque, cacheresp_opaque;
  logic [31:0]  cachereq_addr, cachereq_data, cacheresp_data, memreq_addr;
  logic [127:0] memreq_data, memresp_data;

  row_t        rows [16];
  string       names [16];
  logic [31:0] shadow [1024];                  // Expected word per address
  int          num_rows, errors, checks;
  int          mem_reads = 0;
  int          mem_writes = 0;
  logic [31:0] last_wb_addr;
  bit          timed_out;

  blocking_cache DUT (.*);
  tb_mem main_mem (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Line requests as the memory model sees them
  always @(posedge clk) begin
    if (rst_n && memreq_val && memreq_type == cache_pkg::msg_write) begin
      mem_writes++;
      last_wb_addr = memreq_addr;
    end else if (rst_n && memreq_val) begin
      mem_reads++;
    end
  end

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input logic [2:0] typ, input logic [31:0] addr,
                         input logic [31:0] data, input logic [7:0] opq,
                         input logic [1:0] mem_chk, input logic [31:0] wb_addr);
    row_t r;
    r.typ = typ;
    r.addr = addr;
    r.data = data;
    r.opq = opq;
    r.mem_chk = mem_chk;
    r.wb_addr = wb_addr;
    names[num_rows] = name;
    rows[num_rows]  = r;
    num_rows++;
  endtask

  // Both waits start and end 1 ns after a rising edge
  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (busy && !timed_out) begin
      @(posedge clk);
      #1;
      n++;
      if (n >= timeout_cycles) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout in %s: the cache stayed busy for %0d cycles", name, n);
      end
    end
  endtask

  task automatic wait_response(input string name);
    int n;
    n = 0;
    while (!cacheresp_val && !timed_out) begin
      @(posedge clk);
      #1;
      n++;
      if (n >= timeout_cycles) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout in %s: no response within %0d cycles", name, n);
      end
    end
  endtask

  task automatic apply_row(input int i);
    int reads0, writes0;
    wait_idle(names[i]);
    reads0  = mem_reads;
    writes0 = mem_writes;
    if (!timed_out) begin
      cachereq_val    = 1'b1;
      cachereq_type   = rows[i].typ;
      cachereq_opaque = rows[i].opq;
      cachereq_addr   = rows[i].addr;
      cachereq_data   = rows[i].data;
      if (rows[i].typ == cache_pkg::msg_write) shadow[rows[i].addr[11:2]] = rows[i].data;
      @(posedge clk);
      #1;
      cachereq_val = 1'b0;
      wait_response(names[i]);
    end
    if (!timed_out) begin
      check_value(names[i], "type", rows[i].typ, cacheresp_type);
      check_value(names[i], "opaque", rows[i].opq, cacheresp_opaque);
      if (rows[i].typ == cache_pkg::msg_read)
        check_value(names[i], "data", shadow[rows[i].addr[11:2]], cacheresp_data);
      check_value(names[i], "line reads", (rows[i].mem_chk != chk_hit), mem_reads - reads0);
      check_value(names[i], "line writes", (rows[i].mem_chk == chk_wb), mem_writes - writes0);
      if (rows[i].mem_chk == chk_wb)
        check_value(names[i], "write-back address", rows[i].wb_addr, last_wb_addr);
    end
  endtask

  // ----------------------------------------------------------
  // Request table, set 0 is shared by lines 0x100, 0x180, 0x200
  // ----------------------------------------------------------
  task automatic build_table();
    add_row("rd_miss_040", cache_pkg::msg_read, 32'h040, 32'h0, 8'h11, chk_clean, 32'h0);
    add_row("rd_miss_0a8", cache_pkg::msg_read, 32'h0a8, 32'h0, 8'h12, chk_clean, 32'h0);
    add_row("wr_hit_044", cache_pkg::msg_write, 32'h044, 32'hdeadbeef, 8'h21, chk_hit, 32'h0);
    add_row("rd_hit_044", cache_pkg::msg_read, 32'h044, 32'h0, 8'h22, chk_hit, 32'h0);
    add_row("rd_hit_048", cache_pkg::msg_read, 32'h048, 32'h0, 8'h23, chk_hit, 32'h0);
    add_row("wr_alloc_104", cache_pkg::msg_write, 32'h104, 32'h11110104, 8'h31, chk_clean, 0);
    add_row("wr_alloc_188", cache_pkg::msg_write, 32'h188, 32'h22220188, 8'h32, chk_clean, 0);
    add_row("wr_evict_20c", cache_pkg::msg_write, 32'h20c, 32'h3333020c, 8'h33, chk_wb, 32'h100);
    add_row("rd_back_104", cache_pkg::msg_read, 32'h104, 32'h0, 8'h41, chk_wb, 32'h180);
    add_row("rd_back_188", cache_pkg::msg_read, 32'h188, 32'h0, 8'h42, chk_wb, 32'h200);
    add_row("rd_back_20c", cache_pkg::msg_read, 32'h20c, 32'h0, 8'h43, chk_clean, 32'h0);
    add_row("rd_hit_200", cache_pkg::msg_read, 32'h200, 32'h0, 8'h44, chk_hit, 32'h0);
    add_row("rd_hit_0ac", cache_pkg::msg_read, 32'h0ac, 32'h0, 8'hff, chk_hit, 32'h0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    num_rows = 0;
    timed_out = 1'b0;
    rst_n = 1'b0;
    cachereq_val = 1'b0;
    cachereq_type = cache_pkg::msg_read;
    cachereq_opaque = '0;
    cachereq_addr = '0;
    cachereq_data = '0;
    for (int w = 0; w < 1024; w++) shadow[w] = (w * 4) ^ 32'hf10b0000;
    build_table();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value("after_reset", "busy", 1'b0, busy);
    check_value("after_reset", "cacheresp_val", 1'b0, cacheresp_val);
    check_value("after_reset", "memreq_val", 1'b0, memreq_val);
    for (int i = 0; i < num_rows && !timed_out; i++) apply_row(i);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verif/tb_mem.sv
/*
 * Line-addressed main memory model for the cache testbench.
 * Answers every line request with one memresp_val pulse a fixed latency later.
 */
`timescale 1ns/1ps

module tb_mem (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            memreq_val,
  input  logic [2:0]                      memreq_type,
  input  logic [cache_pkg::addr_bits-1:0] memreq_addr,
  input  logic [cache_pkg::line_bits-1:0] memreq_data,
  output logic                            memresp_val,
  output logic [cache_pkg::line_bits-1:0] memresp_data
);

  localparam int latency   = 3;
  localparam int num_lines = 256;                       // 4 KB backing store

  logic [cache_pkg::line_bits-1:0] lines [num_lines];
  logic [latency-1:0]              resp_pipe;           // One stage per cycle of latency
  logic [7:0]                      line_idx;

  assign line_idx    = memreq_addr[11:4];
  assign memresp_val = resp_pipe[latency-1];

  // Each word starts as its byte address XOR a fixed pattern
  initial begin
    for (int l = 0; l < num_lines; l++) begin
      for (int w = 0; w < 4; w++) begin
        lines[l][w*32 +: 32] = ((l * 16) + (w * 4)) ^ 32'hf10b0000;
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_pipe    <= '0;
      memresp_data <= '0;
    end else begin
      resp_pipe <= {resp_pipe[latency-2:0], memreq_val};
      if (memreq_val && memreq_type == cache_pkg::msg_write) lines[line_idx] <= memreq_data;
      else if (memreq_val) memresp_data <= lines[line_idx];   // Held until the next read
    end
  end

endmodule

//--- design/blocking_cache.sv
/*
 * Two-way write-back blocking cache, top level with plain processor and memory ports.
 */
`timescale 1ns/1ps

module blocking_cache (
  input  logic                             clk,
  input  logic                             rst_n,
  // Processor side
  input  logic                             cachereq_val,
  input  logic [2:0]                       cachereq_type,
  input  logic [cache_pkg::opq_bits-1:0]   cachereq_opaque,
  input  logic [cache_pkg::addr_bits-1:0]  cachereq_addr,
  input  logic [cache_pkg::word_bits-1:0]  cachereq_data,
  output logic                             busy,
  output logic                             cacheresp_val,
  output logic [2:0]                       cacheresp_type,
  output logic [cache_pkg::opq_bits-1:0]   cacheresp_opaque,
  output logic [cache_pkg::word_bits-1:0]  cacheresp_data,
  // Memory side
  output logic                             memreq_val,
  output logic [2:0]                       memreq_type,
  output logic [cache_pkg::addr_bits-1:0]  memreq_addr,
  output logic [cache_pkg::line_bits-1:0]  memreq_data,
  input  logic                             memresp_val,
  input  logic [cache_pkg::line_bits-1:0]  memresp_data
);

  cache_pkg::mem_req_t  cachereq;
  cache_pkg::mem_resp_t cacheresp;
  cache_pkg::line_req_t memreq;

  assign cachereq = {cachereq_type, cachereq_opaque, cachereq_addr, cachereq_data};

  assign cacheresp_type   = cacheresp.msg_type;
  assign cacheresp_opaque = cacheresp.opaque;
  assign cacheresp_data   = cacheresp.data;

  assign memreq_type = memreq.msg_type;
  assign memreq_addr = memreq.addr;
  assign memreq_data = memreq.data;

  cache_ctrl_if ctl_if ();

  cache_ctrl ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cachereq_val  (cachereq_val),
    .memresp_val   (memresp_val),
    .busy          (busy),
    .cacheresp_val (cacheresp_val),
    .memreq_val    (memreq_val),
    .ctl           (ctl_if.ctrl)
  );

  cache_dpath dpath (
    .clk          (clk),
    .rst_n        (rst_n),
    .cachereq     (cachereq),
    .memresp_data (memresp_data),
    .ctl          (ctl_if.dpath),
    .cacheresp    (cacheresp),
    .memreq       (memreq)
  );

endmodule

//--- design/cache_ctrl.sv
/*
 * Cache control FSM holding valid, dirty and LRU state per set.
 * Sequences lookup, write-back, refill and replay through the control interface.
 */
`timescale 1ns/1ps

module cache_ctrl (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cachereq_val,
  input  logic       memresp_val,
  output logic       busy,
  output logic       cacheresp_val,
  output logic       memreq_val,
  cache_ctrl_if.ctrl ctl
);

  typedef enum logic [2:0] {
    st_idle, st_tag_check, st_respond, st_evict_req,
    st_evict_wait, st_refill_req, st_refill_wait, st_refill_write
  } state_t;

  state_t state, next_state;

  logic [1:0][cache_pkg::num_sets-1:0] valid;
  logic [1:0][cache_pkg::num_sets-1:0] dirty;
  logic [cache_pkg::num_sets-1:0]      lru;       // Way to replace next
  logic                                victim_q;

  // ----------------------------------------------------------
  // Hit and victim choice
  // ----------------------------------------------------------
  logic hit0, hit1, hit, is_write, victim, evict_needed;
  logic [15:0] word_wben;

  assign hit0     = valid[0][ctl.req_idx] && ctl.tag0_match;
  assign hit1     = valid[1][ctl.req_idx] && ctl.tag1_match;
  assign hit      = hit0 || hit1;
  assign is_write = (ctl.req_type == cache_pkg::msg_write);

  // Free way first, otherwise the LRU way
  assign victim = !valid[0][ctl.req_idx] ? 1'b0 :
                  !valid[1][ctl.req_idx] ? 1'b1 : lru[ctl.req_idx];
  assign evict_needed = valid[victim][ctl.req_idx] && dirty[victim][ctl.req_idx];

  assign word_wben = 16'h000f << {ctl.req_off, 2'b00};

  // ----------------------------------------------------------
  // State and per-set bookkeeping
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      valid    <= '0;
      dirty    <= '0;
      lru      <= '0;
      victim_q <= 1'b0;
    end else begin
      state <= next_state;
      if (state == st_respond && hit) begin
        lru[ctl.req_idx] <= ~hit1;                         // Other way ages
        if (is_write) dirty[hit1][ctl.req_idx] <= 1'b1;
      end
      if (state == st_respond && !hit) victim_q <= victim;
      if (state == st_refill_write) begin
        valid[victim_q][ctl.req_idx] <= 1'b1;
        dirty[victim_q][ctl.req_idx] <= 1'b0;              // Fresh from memory
      end
    end
  end

  // ----------------------------------------------------------
  // Next state and control outputs
  // ----------------------------------------------------------
  always_comb begin
    next_state         = state;
    busy               = (state != st_idle);
    cacheresp_val      = 1'b0;
    memreq_val         = 1'b0;
    ctl.cachereq_en    = 1'b0;
    ctl.memresp_en     = 1'b0;
    ctl.write_data_sel = 1'b0;
    ctl.tag_ren        = 1'b0;
    ctl.tag0_wen       = 1'b0;
    ctl.tag1_wen       = 1'b0;
    ctl.data_ren       = 1'b0;
    ctl.data0_wen      = 1'b0;
    ctl.data1_wen      = 1'b0;
    ctl.data_wben      = '0;
    ctl.read_data_en   = 1'b0;
    ctl.evict_addr_en  = 1'b0;
    ctl.memreq_addr_sel = 1'b0;
    ctl.way_sel        = victim_q;
    ctl.cacheresp_type = ctl.req_type;
    ctl.memreq_type    = cache_pkg::msg_read;

    case (state)
      st_idle: begin
        ctl.cachereq_en = cachereq_val;
        if (cachereq_val) next_state = st_tag_check;
      end
      st_tag_check: begin                                  // Also the replay after refill
        ctl.tag_ren      = 1'b1;
        ctl.data_ren     = 1'b1;
        ctl.read_data_en = 1'b1;
        next_state       = st_respond;
      end
      st_respond: begin
        if (hit) begin
          cacheresp_val = 1'b1;
          ctl.way_sel   = hit1;
          if (is_write) begin
            ctl.data0_wen = hit0;
            ctl.data1_wen = hit1;
            ctl.data_wben = word_wben;
          end
          next_state = st_idle;
        end else begin
          ctl.evict_addr_en = 1'b1;
          next_state = evict_needed ? st_evict_req : st_refill_req;
        end
      end
      st_evict_req: begin
        memreq_val          = 1'b1;
        ctl.memreq_addr_sel = 1'b1;
        ctl.memreq_type     = cache_pkg::msg_write;
        next_state          = st_evict_wait;
      end
      st_evict_wait: if (memresp_val) next_state = st_refill_req;   // Write ack
      st_refill_req: begin
        memreq_val = 1'b1;
        next_state = st_refill_wait;
      end
      st_refill_wait: begin
        ctl.memresp_en = memresp_val;
        if (memresp_val) next_state = st_refill_write;
      end
      st_refill_write: begin
        ctl.write_data_sel = 1'b1;
        ctl.tag0_wen       = !victim_q;
        ctl.tag1_wen       = victim_q;
        ctl.data0_wen      = !victim_q;
        ctl.data1_wen      = victim_q;
        ctl.data_wben      = '1;
        next_state         = st_tag_check;
      end
      default: next_state = st_idle;
    endcase
  end

endmodule

//--- design/cache_dpath.sv
/*
 * Cache datapath with request and refill registers, two ways and message packing.
 * Steered cycle by cycle by the FSM through the control interface.
 */
`timescale 1ns/1ps

module cache_dpath (
  input  logic                            clk,
  input  logic                            rst_n,
  input  cache_pkg::mem_req_t             cachereq,
  input  logic [cache_pkg::line_bits-1:0] memresp_data,
  cache_ctrl_if.dpath                     ctl,
  output cache_pkg::mem_resp_t            cacheresp,
  output cache_pkg::line_req_t            memreq
);

  // ----------------------------------------------------------
  // Request and refill registers
  // ----------------------------------------------------------
  logic [2:0]                      req_type_q;
  logic [cache_pkg::opq_bits-1:0]  req_opq_q;
  logic [cache_pkg::addr_bits-1:0] req_addr_q;
  logic [cache_pkg::word_bits-1:0] req_data_q;
  logic [cache_pkg::line_bits-1:0] refill_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_type_q <= cache_pkg::msg_read;
      req_opq_q  <= '0;
    end else if (ctl.cachereq_en) begin
      req_type_q <= cachereq.msg_type;
      req_opq_q  <= cachereq.opaque;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.cachereq_en) begin
      req_addr_q <= cachereq.addr;
      req_data_q <= cachereq.data;
    end
    if (ctl.memresp_en) refill_q <= memresp_data;
  end

  assign ctl.req_type = req_type_q;
  assign ctl.req_off  = req_addr_q[2 +: cache_pkg::off_bits];
  assign ctl.req_idx  = req_addr_q[cache_pkg::off_bits+2 +: cache_pkg::idx_bits];

  // Write word copied to every slot, byte enables pick the live one
  logic [cache_pkg::line_bits-1:0] line_wdata;
  assign line_wdata = ctl.write_data_sel ? refill_q : {4{req_data_q}};

  // ----------------------------------------------------------
  // Ways
  // ----------------------------------------------------------
  logic [cache_pkg::addr_bits-1:0] way_addr [2];
  logic [cache_pkg::word_bits-1:0] way_word [2];
  logic [cache_pkg::line_bits-1:0] way_line [2];

  cache_way way0 (
    .clk(clk), .rst_n(rst_n), .req_addr(req_addr_q),
    .tag_ren(ctl.tag_ren), .tag_wen(ctl.tag0_wen),
    .data_ren(ctl.data_ren), .data_wen(ctl.data0_wen),
    .line_wdata(line_wdata), .data_wben(ctl.data_wben),
    .read_data_en(ctl.read_data_en), .evict_addr_en(ctl.evict_addr_en),
    .memreq_addr_sel(ctl.memreq_addr_sel), .word_sel(ctl.req_off),
    .tag_match(ctl.tag0_match), .memreq_addr(way_addr[0]),
    .word_rdata(way_word[0]), .line_rdata(way_line[0])
  );

  cache_way way1 (
    .clk(clk), .rst_n(rst_n), .req_addr(req_addr_q),
    .tag_ren(ctl.tag_ren), .tag_wen(ctl.tag1_wen),
    .data_ren(ctl.data_ren), .data_wen(ctl.data1_wen),
    .line_wdata(line_wdata), .data_wben(ctl.data_wben),
    .read_data_en(ctl.read_data_en), .evict_addr_en(ctl.evict_addr_en),
    .memreq_addr_sel(ctl.memreq_addr_sel), .word_sel(ctl.req_off),
    .tag_match(ctl.tag1_match), .memreq_addr(way_addr[1]),
    .word_rdata(way_word[1]), .line_rdata(way_line[1])
  );

  // ----------------------------------------------------------
  // Way muxes and outgoing messages
  // ----------------------------------------------------------
  assign cacheresp.msg_type = ctl.cacheresp_type;
  assign cacheresp.opaque   = req_opq_q;                // Echo of the request tag
  assign cacheresp.data     = way_word[ctl.way_sel];

  assign memreq.msg_type = ctl.memreq_type;
  assign memreq.addr     = way_addr[ctl.way_sel];
  assign memreq.data     = way_line[ctl.way_sel];      // Only meaningful on write-back

endmodule

//--- design/cache_way.sv
/*
 * One cache way with tag and data arrays, a registered line read and the
 * victim address register. The datapath instantiates one per way.
 */
`timescale 1ns/1ps

module cache_way (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [cache_pkg::addr_bits-1:0] req_addr,
  input  logic                            tag_ren,
  input  logic                            tag_wen,
  input  logic                            data_ren,
  input  logic                            data_wen,
  input  logic [cache_pkg::line_bits-1:0] line_wdata,
  input  logic [15:0]                     data_wben,
  input  logic                            read_data_en,
  input  logic                            evict_addr_en,
  input  logic                            memreq_addr_sel,
  input  logic [cache_pkg::off_bits-1:0]  word_sel,
  output logic                            tag_match,
  output logic [cache_pkg::addr_bits-1:0] memreq_addr,
  output logic [cache_pkg::word_bits-1:0] word_rdata,
  output logic [cache_pkg::line_bits-1:0] line_rdata
);

  localparam int lsb_bits = cache_pkg::off_bits + 2;   // Word offset plus byte offset

  logic [cache_pkg::tag_bits-1:0]  tag_array [cache_pkg::num_sets];
  logic [cache_pkg::line_bits-1:0] data_array [cache_pkg::num_sets];

  logic [cache_pkg::idx_bits-1:0]  idx;
  logic [cache_pkg::tag_bits-1:0]  req_tag;
  logic [cache_pkg::tag_bits-1:0]  tag_rd;               // Stored tag, one cycle after tag_ren
  logic [cache_pkg::addr_bits-1:0] evict_addr;

  assign idx     = req_addr[lsb_bits +: cache_pkg::idx_bits];
  assign req_tag = req_addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];

  // ----------------------------------------------------------
  // Array writes, byte enables cover the whole line
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (tag_wen) tag_array[idx] <= req_tag;
    if (data_wen) begin
      for (int b = 0; b < 16; b++) begin
        if (data_wben[b]) data_array[idx][b*8 +: 8] <= line_wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_rd <= '0;
    end else if (tag_ren) begin
      tag_rd <= tag_array[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (data_ren && read_data_en) line_rdata <= data_array[idx];
    if (evict_addr_en) evict_addr <= {tag_rd, idx, {lsb_bits{1'b0}}};   // Victim line base
  end

  assign tag_match   = (tag_rd == req_tag);           // Valid bit applied in the FSM
  assign word_rdata  = line_rdata[word_sel*cache_pkg::word_bits +: cache_pkg::word_bits];
  assign memreq_addr = memreq_addr_sel ? evict_addr
                                       : {req_addr[cache_pkg::addr_bits-1:lsb_bits],
                                          {lsb_bits{1'b0}}};

endmodule

//--- design/cache_ctrl_if.sv
/*
 * Enables, selects and status between the cache FSM and its datapath.
 * The FSM binds the ctrl modport, the datapath the dpath modport.
 */
`timescale 1ns/1ps

interface cache_ctrl_if;

  // FSM to datapath
  logic                            cachereq_en, memresp_en;
  logic                            write_data_sel;   // 0 write word, 1 refill line
  logic                            tag_ren, tag0_wen, tag1_wen;
  logic                            data_ren, data0_wen, data1_wen;
  logic [cache_pkg::line_bytes-1:0] data_wben;
  logic                            read_data_en, evict_addr_en;
  logic                            memreq_addr_sel;  // 0 request line, 1 victim line
  logic                            way_sel;
  logic [2:0]                      cacheresp_type, memreq_type;

  // Datapath to FSM
  logic                            tag0_match, tag1_match;
  logic [2:0]                      req_type;
  logic [cache_pkg::idx_bits-1:0]  req_idx;
  logic [cache_pkg::off_bits-1:0]  req_off;

  modport ctrl (
    output cachereq_en, memresp_en, write_data_sel, tag_ren, tag0_wen, tag1_wen,
           data_ren, data0_wen, data1_wen, data_wben, read_data_en, evict_addr_en,
           memreq_addr_sel, way_sel, cacheresp_type, memreq_type,
    input  tag0_match, tag1_match, req_type, req_idx, req_off
  );

  modport dpath (
    input  cachereq_en, memresp_en, write_data_sel, tag_ren, tag0_wen, tag1_wen,
           data_ren, data0_wen, data1_wen, data_wben, read_data_en, evict_addr_en,
           memreq_addr_sel, way_sel, cacheresp_type, memreq_type,
    output tag0_match, tag1_match, req_type, req_idx, req_off
  );

endinterface

//--- design/cache_pkg.sv
/*
 * Shared geometry, message codes and message structs for the blocking cache.
 * Referenced by scoped names from the datapath, the control interface and the top.
 */
package cache_pkg;

  // ----------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------
  localparam int cache_bytes = 256;
  localparam int line_bits   = 128;
  localparam int word_bits   = 32;
  localparam int addr_bits   = 32;
  localparam int opq_bits    = 8;
  localparam int line_bytes  = line_bits / 8;             // One write enable per byte

  // Two ways share the capacity
  localparam int num_sets = cache_bytes * 8 / line_bits / 2;
  localparam int idx_bits = $clog2(num_sets);
  localparam int off_bits = $clog2(line_bits / word_bits); // Word within line

  // Address minus index, word offset and byte offset
  localparam int tag_bits = addr_bits - idx_bits - off_bits - $clog2(word_bits / 8);

  // ----------------------------------------------------------
  // Message types
  // ----------------------------------------------------------
  localparam logic [2:0] msg_read  = 3'd0;
  localparam logic [2:0] msg_write = 3'd1;

  // Processor request, 75 bits
  typedef struct packed {
    logic [2:0]           msg_type;
    logic [opq_bits-1:0]  opaque;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] data;
  } mem_req_t;

  // Processor response
  typedef struct packed {
    logic [2:0]           msg_type;
    logic [opq_bits-1:0]  opaque;
    logic [word_bits-1:0] data;
  } mem_resp_t;

  // Line request to main memory
  typedef struct packed {
    logic [2:0]           msg_type;
    logic [addr_bits-1:0] addr;   // Line aligned
    logic [line_bits-1:0] data;
  } line_req_t;

endpackage
